// ==== Makefile ====
SRCS := $(shell grep -v '^+' hl_control.f)

.PHONY: run clean

run: obj_dir/Vtb_hl_control
	@out="$$(./obj_dir/Vtb_hl_control)"; echo "$$out"; echo "$$out" | grep -qx 'Test passed'

obj_dir/Vtb_hl_control: hl_control.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_hl_control \
	  -f hl_control.f -o Vtb_hl_control

clean:
	rm -rf obj_dir

// ==== hl_control.f ====
logic/hl_cmd_pkg.sv
logic/hl_status_pkg.sv
logic/cmd_decoder.sv
logic/tr_sequencer.sv
logic/status_monitor.sv
logic/resp_builder.sv
logic/hl_control.sv
verification/tb_hl_control.sv

// ==== logic/cmd_decoder.sv ====
////////////////////
// Command acceptance and register map. Takes host commands on a
// valid/ready handshake, stores phase and config words, latches PTT and
// asks the response builder for a response when the command wants one.
////////////////////

module cmd_decoder import hl_cmd_pkg::*; (
  input  logic                  clk_ctrl,
  input  logic                  arst_n_i,
  input  logic                  cmd_valid_i,
  output logic                  cmd_ready_o,
  input  logic [CMD_ADDR_W-1:0] cmd_addr_i,
  input  cmd_word_u             cmd_data_i,
  input  logic                  cmd_ptt_i,
  input  logic                  cmd_resp_i,
  input  logic                  resp_pending_i,
  output logic [CMD_DATA_W-1:0] tx_freq_o,
  output logic [CMD_DATA_W-1:0] rx_freq_o,
  output logic                  run_o,
  output logic                  pa_enable_o,
  output logic [HANG_W-1:0]     hang_o,
  output logic [ATTEN_W-1:0]    atten_o,
  output logic                  ptt_o,
  output logic                  capture_o,
  output logic [CMD_DATA_W-1:0] readback_o
);

  logic      rdy_q;
  logic      accept;
  cmd_word_u cfg_rb;

  // ready held back while a response waits on the host
  assign cmd_ready_o = rdy_q & ~resp_pending_i;
  assign accept      = cmd_valid_i & cmd_ready_o;

  // config readback, reserved bits read zero
  always_comb begin
    cfg_rb          = cmd_data_i;
    cfg_rb.cfg.rsvd = '0;
  end

  always_ff @(posedge clk_ctrl or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rdy_q       <= 1'b0;
      tx_freq_o   <= '0;
      rx_freq_o   <= '0;
      run_o       <= 1'b0;
      pa_enable_o <= 1'b0;
      hang_o      <= '0;
      atten_o     <= '0;
      ptt_o       <= 1'b0;
      capture_o   <= 1'b0;
      readback_o  <= '0;
    end else begin
      rdy_q     <= 1'b1;
      capture_o <= accept & cmd_resp_i;
      if (accept) begin
        ptt_o <= cmd_ptt_i;
        case (cmd_addr_i)
          ADDR_TX_FREQ: begin
            tx_freq_o  <= cmd_data_i.freq;
            readback_o <= cmd_data_i.freq;
          end
          ADDR_RX_FREQ: begin
            rx_freq_o  <= cmd_data_i.freq;
            readback_o <= cmd_data_i.freq;
          end
          ADDR_CONFIG: begin
            run_o       <= cmd_data_i.cfg.run;
            pa_enable_o <= cmd_data_i.cfg.pa_enable;
            hang_o      <= cmd_data_i.cfg.hang;
            atten_o     <= cmd_data_i.cfg.atten;
            readback_o  <= cfg_rb.freq;
          end
          // unmapped, nothing stored
          default: readback_o <= '0;
        endcase
      end
    end
  end

  ////////////////////
  // checks

  // a response request must hold off the next command via the builder
  a_resp_blocks_cmd: assert property (
    @(posedge clk_ctrl) disable iff (!arst_n_i)
    (accept && cmd_resp_i) |=> (resp_pending_i && !accept)
  );

endmodule

// ==== logic/hl_cmd_pkg.sv ====
////////////////////
// Command definitions for the control path: address map, field widths
// and the command data word, which decodes as a phase word or as config
// fields depending on the address.
////////////////////

package hl_cmd_pkg;

  localparam int CMD_ADDR_W = 6;
  localparam int CMD_DATA_W = 32;

  // register map
  localparam logic [CMD_ADDR_W-1:0] ADDR_TX_FREQ = 6'd1;
  localparam logic [CMD_ADDR_W-1:0] ADDR_RX_FREQ = 6'd2;
  localparam logic [CMD_ADDR_W-1:0] ADDR_CONFIG  = 6'd9;

  // config field widths
  localparam int HANG_W  = 8;
  localparam int ATTEN_W = 6;

  // one data word, two readings
  typedef union packed {
    logic [CMD_DATA_W-1:0] freq;
    struct packed {
      logic [15:0]        rsvd;
      logic [ATTEN_W-1:0] atten;
      logic [HANG_W-1:0]  hang;
      logic               pa_enable;
      logic               run;
    } cfg;
  } cmd_word_u;

endpackage

// ==== logic/hl_control.sv ====
////////////////////
// Control-domain command path. Commands in on valid/ready, responses
// out on valid/ready, plus TX/RX sequencing, PA lines and status LEDs.
////////////////////

module hl_control import hl_cmd_pkg::*, hl_status_pkg::*; #(
  parameter int SYNC_STAGES      = 2,
  parameter int HANG_UNIT_CYCLES = 4
) (
  input  logic                  clk_ctrl,
  input  logic                  arst_n_i,
  input  logic                  cmd_valid_i,
  output logic                  cmd_ready_o,
  input  logic [CMD_ADDR_W-1:0] cmd_addr_i,
  input  cmd_word_u             cmd_data_i,
  input  logic                  cmd_ptt_i,
  input  logic                  cmd_resp_i,
  output logic                  resp_valid_o,
  input  logic                  resp_ready_i,
  output logic [RESP_W-1:0]     resp_data_o,
  input  logic                  rxclip_i,
  input  logic                  rxgoodlvl_i,
  output logic [CMD_DATA_W-1:0] tx_freq_o,
  output logic [CMD_DATA_W-1:0] rx_freq_o,
  output logic [ATTEN_W-1:0]    atten_o,
  output logic                  tx_on_o,
  output logic                  pa_tr_o,
  output logic                  pa_en_o,
  output logic [LED_W-1:0]      led_o
);

  logic                  run;
  logic                  pa_enable;
  logic [HANG_W-1:0]     hang;
  logic                  ptt;
  logic                  capture;
  logic [CMD_DATA_W-1:0] readback;
  logic                  resp_pending;
  logic                  resp_taken;
  logic                  hang_active;
  logic [STATUS_W-1:0]   status;

  cmd_decoder i_cmd_decoder (
    .clk_ctrl      (clk_ctrl),
    .arst_n_i      (arst_n_i),
    .cmd_valid_i   (cmd_valid_i),
    .cmd_ready_o   (cmd_ready_o),
    .cmd_addr_i    (cmd_addr_i),
    .cmd_data_i    (cmd_data_i),
    .cmd_ptt_i     (cmd_ptt_i),
    .cmd_resp_i    (cmd_resp_i),
    .resp_pending_i(resp_pending),
    .tx_freq_o     (tx_freq_o),
    .rx_freq_o     (rx_freq_o),
    .run_o         (run),
    .pa_enable_o   (pa_enable),
    .hang_o        (hang),
    .atten_o       (atten_o),
    .ptt_o         (ptt),
    .capture_o     (capture),
    .readback_o    (readback)
  );

  tr_sequencer #(.HANG_UNIT_CYCLES(HANG_UNIT_CYCLES)) i_tr_sequencer (
    .clk_ctrl     (clk_ctrl),
    .arst_n_i     (arst_n_i),
    .ptt_i        (ptt),
    .pa_enable_i  (pa_enable),
    .hang_i       (hang),
    .tx_on_o      (tx_on_o),
    .hang_active_o(hang_active),
    .pa_tr_o      (pa_tr_o),
    .pa_en_o      (pa_en_o)
  );

  status_monitor #(.SYNC_STAGES(SYNC_STAGES)) i_status_monitor (
    .clk_ctrl     (clk_ctrl),
    .arst_n_i     (arst_n_i),
    .rxclip_i     (rxclip_i),
    .rxgoodlvl_i  (rxgoodlvl_i),
    .tx_on_i      (tx_on_o),
    .hang_active_i(hang_active),
    .run_i        (run),
    .resp_taken_i (resp_taken),
    .status_o     (status),
    .led_o        (led_o)
  );

  resp_builder i_resp_builder (
    .clk_ctrl    (clk_ctrl),
    .arst_n_i    (arst_n_i),
    .capture_i   (capture),
    .readback_i  (readback),
    .status_i    (status),
    .resp_ready_i(resp_ready_i),
    .resp_valid_o(resp_valid_o),
    .resp_data_o (resp_data_o),
    .pending_o   (resp_pending),
    .resp_taken_o(resp_taken)
  );

endmodule

// ==== logic/hl_status_pkg.sv ====
////////////////////
// Status byte layout and response width, shared by the status monitor,
// the response builder and the testbench.
////////////////////

package hl_status_pkg;

  localparam int STATUS_W = 8;
  localparam int RESP_W   = STATUS_W + hl_cmd_pkg::CMD_DATA_W;

  // status bit positions, upper bits read zero
  localparam int ST_CLIP    = 0;
  localparam int ST_GOODLVL = 1;
  localparam int ST_TX_ON   = 2;
  localparam int ST_HANG    = 3;
  localparam int ST_RUN     = 4;

  localparam int LED_W = 4;

endpackage

// ==== logic/resp_builder.sv ====
////////////////////
// Response builder. Captures status byte and readback word into one
// 40-bit response and holds it on valid/ready until the host takes it.
////////////////////

module resp_builder import hl_cmd_pkg::*, hl_status_pkg::*; (
  input  logic                  clk_ctrl,
  input  logic                  arst_n_i,
  input  logic                  capture_i,
  input  logic [CMD_DATA_W-1:0] readback_i,
  input  logic [STATUS_W-1:0]   status_i,
  input  logic                  resp_ready_i,
  output logic                  resp_valid_o,
  output logic [RESP_W-1:0]     resp_data_o,
  output logic                  pending_o,
  output logic                  resp_taken_o
);

  logic valid_q;

  always_ff @(posedge clk_ctrl or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
    end else if (capture_i) begin
      valid_q <= 1'b1;
    end else if (resp_taken_o) begin
      valid_q <= 1'b0;
    end
  end

  // status byte on top
  always_ff @(posedge clk_ctrl or negedge arst_n_i) begin
    if (!arst_n_i) begin
      resp_data_o <= '0;
    end else if (capture_i) begin
      resp_data_o <= {status_i, readback_i};
    end
  end

  assign resp_valid_o = valid_q;
  assign resp_taken_o = valid_q & resp_ready_i;
  // covers the strobe cycle too, so no command slips in
  assign pending_o    = capture_i | valid_q;

  ////////////////////
  // checks

  a_resp_hold: assert property (
    @(posedge clk_ctrl) disable iff (!arst_n_i)
    (resp_valid_o && !resp_ready_i) |=> (resp_valid_o && $stable(resp_data_o))
  );

endmodule

// ==== logic/status_monitor.sv ====
////////////////////
// Receiver status. Synchronizes the ADC clip and good-level flags,
// keeps clip sticky until a response is taken and registers the
// status byte that feeds responses and LEDs.
////////////////////

module status_monitor import hl_status_pkg::*; #(
  parameter int SYNC_STAGES = 2
) (
  input  logic                clk_ctrl,
  input  logic                arst_n_i,
  input  logic                rxclip_i,
  input  logic                rxgoodlvl_i,
  input  logic                tx_on_i,
  input  logic                hang_active_i,
  input  logic                run_i,
  input  logic                resp_taken_i,
  output logic [STATUS_W-1:0] status_o,
  output logic [LED_W-1:0]    led_o
);

  // bit 0 clip, bit 1 good level
  logic [SYNC_STAGES-1:0][1:0] sync_q;
  logic                        clip_sticky_q;
  logic                        clip_next;
  logic [STATUS_W-1:0]         status_d;

  assign clip_next = sync_q[SYNC_STAGES-1][0] | (clip_sticky_q & ~resp_taken_i);

  always_comb begin
    status_d             = '0;
    status_d[ST_CLIP]    = clip_next;
    status_d[ST_GOODLVL] = sync_q[SYNC_STAGES-1][1];
    status_d[ST_TX_ON]   = tx_on_i;
    status_d[ST_HANG]    = hang_active_i;
    status_d[ST_RUN]     = run_i;
  end

  always_ff @(posedge clk_ctrl or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sync_q        <= '0;
      clip_sticky_q <= 1'b0;
      status_o      <= '0;
    end else begin
      sync_q[0] <= {rxgoodlvl_i, rxclip_i};
      for (int i = 1; i < SYNC_STAGES; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
      clip_sticky_q <= clip_next;
      status_o      <= status_d;
    end
  end

  // led 0 up: clip, good level, tx, run
  assign led_o = {status_o[ST_RUN], status_o[ST_TX_ON], status_o[ST_GOODLVL], status_o[ST_CLIP]};

endmodule

// ==== logic/tr_sequencer.sv ====
////////////////////
// Transmit/receive sequencing. PTT gated by the PA-enable bit drives
// tx_on and the PA T/R line; a hang counter keeps transmit up for
// hang x HANG_UNIT_CYCLES cycles after PTT drops.
////////////////////

module tr_sequencer import hl_cmd_pkg::*; #(
  parameter int HANG_UNIT_CYCLES = 4
) (
  input  logic              clk_ctrl,
  input  logic              arst_n_i,
  input  logic              ptt_i,
  input  logic              pa_enable_i,
  input  logic [HANG_W-1:0] hang_i,
  output logic              tx_on_o,
  output logic              hang_active_o,
  output logic              pa_tr_o,
  output logic              pa_en_o
);

  localparam int CNT_W = HANG_W + $clog2(HANG_UNIT_CYCLES + 1);
  localparam logic [CNT_W-1:0] UNIT = CNT_W'(HANG_UNIT_CYCLES);

  localparam logic [1:0] S_RX   = 2'd0;
  localparam logic [1:0] S_TX   = 2'd1;
  localparam logic [1:0] S_HANG = 2'd2;

  logic [1:0]       state_q;
  logic [CNT_W-1:0] hang_cnt_q;
  logic [CNT_W-1:0] hang_len;
  logic             pa_en_q;

  assign hang_len = CNT_W'(hang_i) * UNIT;

  always_ff @(posedge clk_ctrl or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q    <= S_RX;
      hang_cnt_q <= '0;
      pa_en_q    <= 1'b0;
    end else begin
      pa_en_q <= pa_enable_i;
      case (state_q)
        S_RX: begin
          if (ptt_i && pa_enable_i) state_q <= S_TX;
        end
        S_TX: begin
          if (!pa_enable_i) begin
            state_q <= S_RX;
          end else if (!ptt_i) begin
            // zero hang drops straight back to receive
            if (hang_len == '0) begin
              state_q <= S_RX;
            end else begin
              state_q    <= S_HANG;
              hang_cnt_q <= hang_len - CNT_W'(1);
            end
          end
        end
        S_HANG: begin
          if (!pa_enable_i) state_q <= S_RX;
          else if (ptt_i) state_q <= S_TX;
          else if (hang_cnt_q == '0) state_q <= S_RX;
          else hang_cnt_q <= hang_cnt_q - CNT_W'(1);
        end
        default: state_q <= S_RX;
      endcase
    end
  end

  assign tx_on_o       = (state_q != S_RX);
  assign hang_active_o = (state_q == S_HANG);
  assign pa_tr_o       = tx_on_o;
  assign pa_en_o       = pa_en_q;

  // PA disable always wins within one cycle
  a_pa_gate: assert property (
    @(posedge clk_ctrl) disable iff (!arst_n_i)
    !pa_enable_i |=> !tx_on_o
  );

endmodule

// ==== verification/tb_hl_control.sv ====
////////////////////
// Testbench for the control path. Directed tests drive commands and ADC
// flags, then check registers, responses, TX sequencing and LEDs.
////////////////////

module tb_hl_control import hl_cmd_pkg::*, hl_status_pkg::*; ();

  localparam int SYNC_STAGES = 2;
  localparam int HANG_UNITS  = 4;
  localparam int MAX_CYCLES  = 5000;
  localparam logic [CMD_ADDR_W-1:0] ADDR_UNMAPPED = 6'd5;

  logic                  clk_ctrl = 1'b0;
  logic                  arst_n_i;
  logic                  cmd_valid_i;
  logic                  cmd_ready_o;
  logic [CMD_ADDR_W-1:0] cmd_addr_i;
  cmd_word_u             cmd_data_i;
  logic                  cmd_ptt_i;
  logic                  cmd_resp_i;
  logic                  resp_valid_o;
  logic                  resp_ready_i;
  logic [RESP_W-1:0]     resp_data_o;
  logic                  rxclip_i;
  logic                  rxgoodlvl_i;
  logic [CMD_DATA_W-1:0] tx_freq_o;
  logic [CMD_DATA_W-1:0] rx_freq_o;
  logic [ATTEN_W-1:0]    atten_o;
  logic                  tx_on_o;
  logic                  pa_tr_o;
  logic                  pa_en_o;
  logic [LED_W-1:0]      led_o;
  int                    cycle_cnt = 0;

  hl_control #(.SYNC_STAGES(SYNC_STAGES), .HANG_UNIT_CYCLES(HANG_UNITS)) i_dut (.*);

  always #5 clk_ctrl = ~clk_ctrl;

  ////////////////////
  // run limit and checks

  always @(posedge clk_ctrl) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      abort_run($sformatf("timeout: run went past %0d cycles", MAX_CYCLES));
    end
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_resp(input string name, input logic [RESP_W-1:0] exp,
                            input logic [RESP_W-1:0] act);
    if (act !== exp) abort_run($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
  endtask

  task automatic check_word(input string name, input cmd_word_u exp, input cmd_word_u act);
    if (act !== exp) abort_run($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
  endtask

  task automatic check_atten(input string name, input logic [ATTEN_W-1:0] exp,
                             input logic [ATTEN_W-1:0] act);
    if (act !== exp) abort_run($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) abort_run($sformatf("mismatch %s: expected %b, actual %b", name, exp, act));
  endtask

  ////////////////////
  // bus helpers

  // inputs change just after the rising edge
  task automatic next_cycle();
    @(posedge clk_ctrl);
    #1;
  endtask

  task automatic send_cmd(input logic [CMD_ADDR_W-1:0] addr, input cmd_word_u data,
                          input logic ptt, input logic resp);
    cmd_valid_i = 1'b1;
    cmd_addr_i  = addr;
    cmd_data_i  = data;
    cmd_ptt_i   = ptt;
    cmd_resp_i  = resp;
    while (!cmd_ready_o) next_cycle();
    next_cycle();
    cmd_valid_i = 1'b0;
  endtask

  task automatic take_resp(output logic [RESP_W-1:0] resp);
    resp_ready_i = 1'b1;
    while (!resp_valid_o) next_cycle();
    resp = resp_data_o;
    next_cycle();
    resp_ready_i = 1'b0;
  endtask

  ////////////////////
  // directed tests

  task automatic test_regmap();
    cmd_word_u         tx_w;
    cmd_word_u         rx_w;
    cmd_word_u         un_w;
    logic [RESP_W-1:0] resp;
    tx_w.freq = $urandom();
    rx_w.freq = $urandom();
    un_w.freq = $urandom();
    send_cmd(ADDR_TX_FREQ, tx_w, 1'b0, 1'b1);
    take_resp(resp);
    // nothing set in status yet
    check_resp("regmap tx response", {8'h00, tx_w.freq}, resp);
    check_word("regmap tx_freq", tx_w, cmd_word_u'(tx_freq_o));
    send_cmd(ADDR_RX_FREQ, rx_w, 1'b0, 1'b1);
    take_resp(resp);
    check_resp("regmap rx response", {8'h00, rx_w.freq}, resp);
    check_word("regmap rx_freq", rx_w, cmd_word_u'(rx_freq_o));
    send_cmd(ADDR_UNMAPPED, un_w, 1'b0, 1'b1);
    take_resp(resp);
    check_resp("regmap unmapped response", '0, resp);
    check_word("regmap tx_freq kept", tx_w, cmd_word_u'(tx_freq_o));
    check_word("regmap rx_freq kept", rx_w, cmd_word_u'(rx_freq_o));
    check_atten("regmap atten kept", '0, atten_o);
  endtask

  task automatic test_config();
    cmd_word_u         cfg;
    logic [RESP_W-1:0] resp;
    cfg               = '0;
    cfg.cfg.atten     = 6'h2a;
    cfg.cfg.hang      = 8'd3;
    cfg.cfg.pa_enable = 1'b1;
    cfg.cfg.run       = 1'b1;
    send_cmd(ADDR_CONFIG, cfg, 1'b0, 1'b1);
    take_resp(resp);
    check_word("config readback", cfg, cmd_word_u'(resp[CMD_DATA_W-1:0]));
    check_atten("config atten", cfg.cfg.atten, atten_o);
    check_bit("config pa_en", 1'b1, pa_en_o);
    check_bit("config run led", 1'b1, led_o[3]);
    // status byte is sampled before this write lands, so ask again
    send_cmd(ADDR_CONFIG, cfg, 1'b0, 1'b1);
    take_resp(resp);
    check_bit("config status run", 1'b1, resp[CMD_DATA_W+ST_RUN]);
  endtask

  task automatic test_backpressure();
    cmd_word_u         word;
    logic [RESP_W-1:0] held;
    word.freq = $urandom();
    send_cmd(ADDR_RX_FREQ, word, 1'b0, 1'b1);
    while (!resp_valid_o) next_cycle();
    held = resp_data_o;
    check_word("backpressure data", word, cmd_word_u'(held[CMD_DATA_W-1:0]));
    repeat (20) begin
      next_cycle();
      check_bit("backpressure valid", 1'b1, resp_valid_o);
      check_resp("backpressure hold", held, resp_data_o);
      check_bit("backpressure cmd_ready", 1'b0, cmd_ready_o);
    end
    resp_ready_i = 1'b1;
    next_cycle();
    resp_ready_i = 1'b0;
    check_bit("backpressure valid drop", 1'b0, resp_valid_o);
    check_bit("backpressure cmd_ready back", 1'b1, cmd_ready_o);
  endtask

  task automatic test_tx_seq();
    cmd_word_u cfg;
    int        hang_cycles;
    cfg               = '0;
    cfg.cfg.hang      = 8'd5;
    cfg.cfg.pa_enable = 1'b1;
    cfg.cfg.run       = 1'b1;
    send_cmd(ADDR_CONFIG, cfg, 1'b1, 1'b0);
    check_bit("tx before ptt seen", 1'b0, tx_on_o);
    next_cycle();
    check_bit("tx_on after ptt", 1'b1, tx_on_o);
    check_bit("pa_tr after ptt", 1'b1, pa_tr_o);
    repeat (5) next_cycle();
    check_bit("tx_on led", 1'b1, led_o[2]);
    send_cmd(ADDR_CONFIG, cfg, 1'b0, 1'b0);
    // one cycle for the release to reach the sequencer
    next_cycle();
    hang_cycles = 0;
    while (tx_on_o && hang_cycles < 100) begin
      hang_cycles++;
      next_cycle();
    end
    if (hang_cycles != 5 * HANG_UNITS) begin
      abort_run($sformatf("mismatch tx hang length: expected %0d, actual %0d",
                          5 * HANG_UNITS, hang_cycles));
    end
    check_bit("pa_tr after hang", 1'b0, pa_tr_o);
    cfg.cfg.pa_enable = 1'b0;
    send_cmd(ADDR_CONFIG, cfg, 1'b1, 1'b0);
    repeat (10) begin
      next_cycle();
      check_bit("tx with pa disabled", 1'b0, tx_on_o);
    end
    check_bit("pa_en disabled", 1'b0, pa_en_o);
    send_cmd(ADDR_CONFIG, cfg, 1'b0, 1'b0);
  endtask

  task automatic test_status();
    cmd_word_u         word;
    logic [RESP_W-1:0] resp;
    word.freq   = $urandom();
    rxgoodlvl_i = 1'b1;
    rxclip_i    = 1'b1;
    repeat (3) next_cycle();
    rxclip_i = 1'b0;
    repeat (SYNC_STAGES + 3) next_cycle();
    check_bit("status clip led", 1'b1, led_o[0]);
    check_bit("status goodlvl led", 1'b1, led_o[1]);
    send_cmd(ADDR_TX_FREQ, word, 1'b0, 1'b1);
    take_resp(resp);
    check_bit("status first clip", 1'b1, resp[CMD_DATA_W+ST_CLIP]);
    check_bit("status first goodlvl", 1'b1, resp[CMD_DATA_W+ST_GOODLVL]);
    send_cmd(ADDR_TX_FREQ, word, 1'b0, 1'b1);
    take_resp(resp);
    check_bit("status second clip", 1'b0, resp[CMD_DATA_W+ST_CLIP]);
    check_bit("status second goodlvl", 1'b1, resp[CMD_DATA_W+ST_GOODLVL]);
    check_bit("status clip led cleared", 1'b0, led_o[0]);
  endtask

  initial begin
    void'($urandom(26182));
    arst_n_i     = 1'b0;
    cmd_valid_i  = 1'b0;
    cmd_addr_i   = '0;
    cmd_data_i   = '0;
    cmd_ptt_i    = 1'b0;
    cmd_resp_i   = 1'b0;
    resp_ready_i = 1'b0;
    rxclip_i     = 1'b0;
    rxgoodlvl_i  = 1'b0;
    repeat (5) @(posedge clk_ctrl);
    #1;
    arst_n_i = 1'b1;
    next_cycle();
    test_regmap();
    test_config();
    test_backpressure();
    test_tx_seq();
    test_status();
    $display("Test passed");
    $finish;
  end

endmodule
